// ==== hw/csr_decode.sv ====
// first pipeline stage of the CSR unit: decodes a Zicsr word and registers its fields for execute
`timescale 1ns/1ps

module csr_decode import csr_pkg::*; (
    input  logic            clk,
    input  logic            rst,           // synchronous, active low
    input  logic            inst_valid,    // one-cycle strobe, may be high every cycle
    input  csr_inst_u       inst,
    input  logic [XLEN-1:0] rs1_data,      // rs1 value, valid with inst
    output logic            dec_valid,
    output csr_op_e         dec_op,
    output logic [11:0]     dec_addr,
    output logic [4:0]      dec_rd,
    output logic [XLEN-1:0] dec_operand,
    output logic            dec_do_write,  // low when set or clear has a zero source field
    output logic            dec_is_system  // low for a foreign opcode or funct3
);

    logic            use_imm;      // funct3 bit 2 picks the immediate view
    logic [4:0]      src_field;    // rs1 index or zimm, both sit at bits 19:15
    logic [XLEN-1:0] operand_next;
    csr_op_e         op_next;
    logic            f3_ok;        // funct3 is one of the six Zicsr codes
    logic            opc_ok;

    always_comb begin
        use_imm = inst.regf.funct3[2];
        src_field = inst.regf.rs1; // zimm occupies the same bits in the other view
        operand_next = use_imm ? {{(XLEN-5){1'b0}}, inst.immf.zimm} : rs1_data; // zimm zero-extends
        opc_ok = (inst.regf.opcode == OPC_SYSTEM);
        f3_ok = 1'b1;
        op_next = CSR_OP_WRITE; // a defined value even for a rejected word
        case (inst.regf.funct3)
            F3_CSRRW, F3_CSRRWI: op_next = CSR_OP_WRITE;
            F3_CSRRS, F3_CSRRSI: op_next = CSR_OP_SET;
            F3_CSRRC, F3_CSRRCI: op_next = CSR_OP_CLEAR;
            default:             f3_ok = 1'b0; // 000 and 100 are not CSR ops
        endcase
    end

    // only the strobe needs a reset, the fields below are qualified by it
    always_ff @(posedge clk) begin
        if (!rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        dec_op <= op_next;
        dec_addr <= inst.regf.csr;   // address sits at the same place in both views
        dec_rd <= inst.regf.rd;
        dec_operand <= operand_next;
        // set and clear with a zero field only read, so a read-only CSR stays legal
        dec_do_write <= (op_next == CSR_OP_WRITE) || (src_field != 5'd0);
        dec_is_system <= opc_ok && f3_ok; // such a word is dropped as illegal in execute
    end

    // the unused 2'b00 encoding must never reach execute
    a_dec_op_defined: assert property (@(posedge clk) disable iff (!rst)
        dec_valid |-> dec_op inside {CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR})
        else $error("decode produced undefined op %b", dec_op);

endmodule

// ==== hw/csr_execute.sv ====
// execute stage of the CSR unit: reads the file, forms the new CSR and rd values, judges legality
`timescale 1ns/1ps

module csr_execute import csr_pkg::*; (
    input  logic            dec_valid,
    input  csr_op_e         dec_op,
    input  logic [11:0]     dec_addr,
    input  logic [4:0]      dec_rd,
    input  logic [XLEN-1:0] dec_operand,
    input  logic            dec_do_write,
    input  logic            dec_is_system,
    input  logic [XLEN-1:0] csr_rdata,     // old value, combinational from the file
    input  logic            csr_exists,
    input  logic            csr_read_only,
    output logic [11:0]     rd_csr_addr,
    output logic            csr_we,        // lands at the edge that ends this cycle
    output logic [11:0]     csr_waddr,
    output logic [XLEN-1:0] csr_wdata,
    output logic            ex_valid,
    output logic [4:0]      ex_rd,
    output logic [XLEN-1:0] ex_value,      // old CSR value bound for rd
    output logic            ex_illegal
);

    logic [XLEN-1:0] new_value;
    logic            access_bad; // true for any reason the access must not happen

    always_comb begin
        rd_csr_addr = dec_addr; // read port always follows the instruction in execute

        // read-modify-write on the old value
        case (dec_op)
            CSR_OP_SET:   new_value = csr_rdata | dec_operand;
            CSR_OP_CLEAR: new_value = csr_rdata & ~dec_operand;
            default:      new_value = dec_operand;
        endcase

        // a read-only CSR is fine as long as nothing is written to it
        access_bad = !dec_is_system || !csr_exists || (dec_do_write && csr_read_only);

        csr_we = dec_valid && dec_do_write && !access_bad;
        csr_waddr = dec_addr;
        csr_wdata = new_value; // the file applies its own field masks

        ex_valid = dec_valid;
        ex_rd = dec_rd;
        ex_value = csr_rdata; // rd always gets the value before the update
        ex_illegal = dec_valid && access_bad;

        // an illegal access must leave every CSR untouched
        assert (!(csr_we && ex_illegal))
            else $error("CSR write issued for illegal access at %h", dec_addr);
    end

endmodule

// ==== hw/csr_file.sv ====
// machine-mode CSR storage with a combinational read port and masked writes, driven by execute
`timescale 1ns/1ps

module csr_file import csr_pkg::*; #(
    parameter logic [XLEN-1:0] MISA_VALUE = 32'h4000_0100 // value returned for misa
) (
    input  logic            clk,
    input  logic            rst,           // synchronous, active low
    input  logic [11:0]     rd_csr_addr,
    input  logic            csr_we,
    input  logic [11:0]     csr_waddr,
    input  logic [XLEN-1:0] csr_wdata,
    output logic [XLEN-1:0] csr_rdata,     // zero for an address that does not exist
    output logic            csr_exists,
    output logic            csr_read_only
);

    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtvec;

    // read port decode, no pipeline so a write is seen by the next cycle's read
    always_comb begin
        csr_rdata = '0;
        csr_exists = 1'b1;
        csr_read_only = 1'b0;
        case (rd_csr_addr)
            CSR_MISA: begin
                csr_rdata = MISA_VALUE;
                csr_read_only = 1'b1; // constant, writes are rejected upstream
            end
            CSR_MTVEC:    csr_rdata = mtvec;
            CSR_MSCRATCH: csr_rdata = mscratch;
            CSR_MEPC:     csr_rdata = mepc;
            CSR_MCAUSE:   csr_rdata = mcause;
            default:      csr_exists = 1'b0; // execute turns this into an illegal access
        endcase
    end

    // register state, all zero out of reset
    always_ff @(posedge clk) begin
        if (!rst) begin
            mscratch <= '0;
            mepc <= '0;
            mcause <= '0;
            mtvec <= '0;
        end else if (csr_we) begin
            case (csr_waddr)
                CSR_MTVEC:    mtvec <= {csr_wdata[XLEN-1:2], 2'b00}; // only direct mode, aligned
                CSR_MSCRATCH: mscratch <= csr_wdata;
                CSR_MEPC:     mepc <= {csr_wdata[XLEN-1:1], 1'b0}; // no odd pc without C
                CSR_MCAUSE:   mcause <= csr_wdata; // WLRL, kept as written
                default:      ; // misa has no storage
            endcase
        end
    end

    // execute must have filtered any write aimed at the read-only misa
    a_no_misa_write: assert property (@(posedge clk) disable iff (!rst)
        !(csr_we && csr_waddr == CSR_MISA))
        else $error("write reached misa with data %h", csr_wdata);

endmodule

// ==== hw/csr_pkg.sv ====
// shared CSR encodings and the Zicsr instruction layout, imported by every block of the CSR unit
package csr_pkg;

    localparam int XLEN = 32; // RV32 data path width

    // opcode of every Zicsr instruction
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011; // SYSTEM major opcode

    // funct3 codes, bit 2 set means the source is the 5-bit immediate
    localparam logic [2:0] F3_CSRRW  = 3'b001; // read-write from rs1
    localparam logic [2:0] F3_CSRRS  = 3'b010; // read-set from rs1
    localparam logic [2:0] F3_CSRRC  = 3'b011; // read-clear from rs1
    localparam logic [2:0] F3_CSRRWI = 3'b101; // read-write from zimm
    localparam logic [2:0] F3_CSRRSI = 3'b110; // read-set from zimm
    localparam logic [2:0] F3_CSRRCI = 3'b111; // read-clear from zimm

    // machine-mode registers held by the CSR file
    localparam logic [11:0] CSR_MISA     = 12'h301; // read-only ISA description
    localparam logic [11:0] CSR_MTVEC    = 12'h305; // trap vector base, direct mode only
    localparam logic [11:0] CSR_MSCRATCH = 12'h340; // free scratch word for the handler
    localparam logic [11:0] CSR_MEPC     = 12'h341; // exception pc, always halfword aligned
    localparam logic [11:0] CSR_MCAUSE   = 12'h342; // trap cause, stored as written

    // the three operations, encoded like funct3[1:0] so 2'b00 stays unused
    typedef enum logic [1:0] {
        CSR_OP_WRITE = 2'b01, // new value is the operand
        CSR_OP_SET   = 2'b10, // new value is old OR operand
        CSR_OP_CLEAR = 2'b11  // new value is old AND NOT operand
    } csr_op_e;

    // register form, bits 19:15 name the source register
    typedef struct packed {
        logic [11:0] csr;    // CSR address
        logic [4:0]  rs1;    // source register index
        logic [2:0]  funct3; // operation and source select
        logic [4:0]  rd;     // destination register index
        logic [6:0]  opcode; // must be OPC_SYSTEM
    } csr_reg_fmt;

    // immediate form, bits 19:15 are a zero-extended constant
    typedef struct packed {
        logic [11:0] csr;    // CSR address
        logic [4:0]  zimm;   // unsigned immediate operand
        logic [2:0]  funct3; // operation and source select
        logic [4:0]  rd;     // destination register index
        logic [6:0]  opcode; // must be OPC_SYSTEM
    } csr_imm_fmt;

    // one instruction word, viewed by funct3 bit 2
    typedef union packed {
        csr_reg_fmt regf; // view for CSRRW, CSRRS, CSRRC
        csr_imm_fmt immf; // view for CSRRWI, CSRRSI, CSRRCI
    } csr_inst_u;

endpackage

// ==== hw/csr_result.sv ====
// last stage of the CSR unit: registers the register-file writeback and the illegal pulse
`timescale 1ns/1ps

module csr_result import csr_pkg::*; (
    input  logic            clk,
    input  logic            rst,       // synchronous, active low
    input  logic            ex_valid,
    input  logic [4:0]      ex_rd,
    input  logic [XLEN-1:0] ex_value,
    input  logic            ex_illegal,
    output logic            rd_we,     // one pulse per legal access with rd != x0
    output logic [4:0]      rd_addr,
    output logic [XLEN-1:0] rd_wdata,
    output logic            illegal    // one pulse per rejected access
);

    // strobes are control state and clear on reset
    always_ff @(posedge clk) begin
        if (!rst) begin
            rd_we <= 1'b0;
            illegal <= 1'b0;
        end else begin
            rd_we <= ex_valid && !ex_illegal && (ex_rd != 5'd0); // x0 is never written
            illegal <= ex_valid && ex_illegal;
        end
    end

    // destination and data only mean something under rd_we
    always_ff @(posedge clk) begin
        rd_addr <= ex_rd;
        rd_wdata <= ex_value;
    end

endmodule

// ==== hw/csr_unit_top.sv ====
// top level of the CSR unit: one Zicsr instruction in per cycle, writeback strobes out two edges later
`timescale 1ns/1ps

module csr_unit_top import csr_pkg::*; #(
    parameter logic [XLEN-1:0] MISA_VALUE = 32'h4000_0100 // RV32I, passed to the file
) (
    input  logic            clk,
    input  logic            rst,        // synchronous, active low
    input  logic            inst_valid,
    input  logic [31:0]     inst,
    input  logic [XLEN-1:0] rs1_data,
    output logic            rd_we,
    output logic [4:0]      rd_addr,
    output logic [XLEN-1:0] rd_wdata,
    output logic            illegal
);

    logic            dec_valid;
    csr_op_e         dec_op;
    logic [11:0]     dec_addr;
    logic [4:0]      dec_rd;
    logic [XLEN-1:0] dec_operand;
    logic            dec_do_write;
    logic            dec_is_system;
    logic [11:0]     rd_csr_addr;
    logic [XLEN-1:0] csr_rdata;
    logic            csr_exists;
    logic            csr_read_only;
    logic            csr_we;
    logic [11:0]     csr_waddr;
    logic [XLEN-1:0] csr_wdata;
    logic            ex_valid;
    logic [4:0]      ex_rd;
    logic [XLEN-1:0] ex_value;
    logic            ex_illegal;

    csr_decode csr_decode_inst (
        .clk, .rst, .inst_valid, .inst(csr_inst_u'(inst)), .rs1_data,
        .dec_valid, .dec_op, .dec_addr, .dec_rd, .dec_operand, .dec_do_write, .dec_is_system
    );

    csr_execute csr_execute_inst (
        .dec_valid, .dec_op, .dec_addr, .dec_rd, .dec_operand, .dec_do_write, .dec_is_system,
        .csr_rdata, .csr_exists, .csr_read_only, .rd_csr_addr, .csr_we, .csr_waddr, .csr_wdata,
        .ex_valid, .ex_rd, .ex_value, .ex_illegal
    );

    csr_file #(.MISA_VALUE(MISA_VALUE)) csr_file_inst (
        .clk, .rst, .rd_csr_addr, .csr_we, .csr_waddr, .csr_wdata,
        .csr_rdata, .csr_exists, .csr_read_only
    );

    csr_result csr_result_inst (
        .clk, .rst, .ex_valid, .ex_rd, .ex_value, .ex_illegal,
        .rd_we, .rd_addr, .rd_wdata, .illegal
    );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build the CSR unit testbench with Verilator, run it and exit nonzero on failure
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module csr_unit_tb \
    --Mdir obj_dir -o csr_unit_sim

./obj_dir/csr_unit_sim | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failure"

// ==== tb/csr_unit_tb.sv ====
// self-checking testbench for the CSR unit, run as top with the RTL from vlog.f through run.sh
`timescale 1ns/1ps

module csr_unit_tb import csr_pkg::*; ();

    localparam logic [XLEN-1:0] MISA = 32'h4000_1104; // RV32 with I, M and C set
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int N_DIRECTED   = 100; // upper bound on directed instructions and gaps
    localparam int N_RANDOM     = 300;
    localparam int MARGIN       = 50;
    localparam logic [11:0] RW_CSR [4] = '{CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE};
    // random address pool, misa once and one address that does not exist
    localparam logic [11:0] ANY_CSR [8] = '{CSR_MISA, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC,
                                            CSR_MCAUSE, CSR_MSCRATCH, CSR_MTVEC, 12'h7c0};

    logic            clk;
    logic            rst;
    logic            inst_valid;
    logic [31:0]     inst;
    logic [XLEN-1:0] rs1_data;
    logic            rd_we;
    logic [4:0]      rd_addr;
    logic [XLEN-1:0] rd_wdata;
    logic            illegal;

    logic [XLEN-1:0] m_mscratch; // reference copies of the writable CSRs
    logic [XLEN-1:0] m_mepc;
    logic [XLEN-1:0] m_mcause;
    logic [XLEN-1:0] m_mtvec;

    logic            exp0_we;    // stage 0 is set together with the stimulus
    logic            exp0_ill;
    logic [4:0]      exp0_addr;
    logic [XLEN-1:0] exp0_data;
    logic            exp1_we;
    logic            exp1_ill;
    logic [4:0]      exp1_addr;
    logic [XLEN-1:0] exp1_data;
    logic            exp2_we;    // stage 2 lines up with the DUT outputs
    logic            exp2_ill;
    logic [4:0]      exp2_addr;
    logic [XLEN-1:0] exp2_data;

    integer seed;
    int     checked = 0;
    int     err_we = 0;
    int     err_ill = 0;
    int     err_addr = 0;
    int     err_data = 0;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    csr_unit_top #(.MISA_VALUE(MISA)) csr_unit_top_inst (
        .clk, .rst, .inst_valid, .inst, .rs1_data, .rd_we, .rd_addr, .rd_wdata, .illegal
    );

    // two-edge delay line, matching decode plus result registers
    always @(posedge clk) begin
        exp1_we <= exp0_we;
        exp1_ill <= exp0_ill;
        exp1_addr <= exp0_addr;
        exp1_data <= exp0_data;
        exp2_we <= exp1_we;
        exp2_ill <= exp1_ill;
        exp2_addr <= exp1_addr;
        exp2_data <= exp1_data;
        if (rst) checked <= checked + 1; // one compare per cycle out of reset
    end

    a_rd_we: assert property (@(posedge clk) disable iff (!rst) rd_we == exp2_we)
        else begin
            err_we++;
            $display("** Error rd_we: got %h expected %h at %0t", rd_we, exp2_we, $time);
        end
    a_illegal: assert property (@(posedge clk) disable iff (!rst) illegal == exp2_ill)
        else begin
            err_ill++;
            $display("** Error illegal: got %h expected %h at %0t", illegal, exp2_ill, $time);
        end
    a_rd_addr: assert property (@(posedge clk) disable iff (!rst)
        exp2_we |-> rd_addr == exp2_addr)
        else begin
            err_addr++;
            $display("** Error rd_addr: got %h expected %h at %0t", rd_addr, exp2_addr, $time);
        end
    a_rd_wdata: assert property (@(posedge clk) disable iff (!rst)
        exp2_we |-> rd_wdata == exp2_data)
        else begin
            err_data++;
            $display("** Error rd_wdata: got %h expected %h at %0t", rd_wdata, exp2_data, $time);
        end

    function automatic logic [31:0] csr_word(input logic [11:0] addr, input logic [4:0] src,
                                             input logic [2:0] f3, input logic [4:0] rd);
        return {addr, src, f3, rd, OPC_SYSTEM};
    endfunction

    // reference read port, zero with exists low for an unknown address
    function automatic logic [XLEN-1:0] model_read(input logic [11:0] addr, output logic exists,
                                                   output logic ro);
        logic [XLEN-1:0] val;
        val = '0;
        exists = 1'b1;
        ro = (addr == CSR_MISA);
        case (addr)
            CSR_MISA:     val = MISA;
            CSR_MTVEC:    val = m_mtvec;
            CSR_MSCRATCH: val = m_mscratch;
            CSR_MEPC:     val = m_mepc;
            CSR_MCAUSE:   val = m_mcause;
            default:      exists = 1'b0;
        endcase
        return val;
    endfunction

    task automatic model_write(input logic [11:0] addr, input logic [XLEN-1:0] value);
        case (addr)
            CSR_MTVEC:    m_mtvec = {value[XLEN-1:2], 2'b00}; // vector base is word aligned
            CSR_MSCRATCH: m_mscratch = value;
            CSR_MEPC:     m_mepc = {value[XLEN-1:1], 1'b0};   // pc bit 0 always reads zero
            CSR_MCAUSE:   m_mcause = value;
            default:      ;
        endcase
    endtask

    // drive one instruction and run it through the reference model at the same time
    task automatic issue(input logic [31:0] word, input logic [XLEN-1:0] rs1v);
        logic [2:0]      f3;
        logic [4:0]      src;
        logic [XLEN-1:0] operand;
        logic [XLEN-1:0] old;
        logic            exists;
        logic            ro;
        logic            do_wr;
        logic            bad;
        @(posedge clk);
        #1;
        inst_valid = 1'b1;
        inst = word;
        rs1_data = rs1v;
        f3 = word[14:12];
        src = word[19:15];
        operand = f3[2] ? {27'd0, src} : rs1v; // zimm is zero-extended
        do_wr = (f3[1:0] == 2'b01) || (src != 5'd0); // set or clear with x0 or 0 only reads
        old = model_read(word[31:20], exists, ro);
        bad = (word[6:0] != OPC_SYSTEM) || !(f3 inside {F3_CSRRW, F3_CSRRS, F3_CSRRC,
              F3_CSRRWI, F3_CSRRSI, F3_CSRRCI}) || !exists || (do_wr && ro);
        if (!bad && do_wr) begin
            case (f3[1:0])
                2'b10:   model_write(word[31:20], old | operand);
                2'b11:   model_write(word[31:20], old & ~operand);
                default: model_write(word[31:20], operand);
            endcase
        end
        exp0_we = !bad && (word[11:7] != 5'd0); // x0 is never written back
        exp0_ill = bad;
        exp0_addr = word[11:7];
        exp0_data = old;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            inst_valid = 1'b0;
            inst = $random(seed); // junk on inst must be ignored without the strobe
            exp0_we = 1'b0;
            exp0_ill = 1'b0;
        end
    endtask

    task automatic read_all();
        issue(csr_word(CSR_MISA, 5'd0, F3_CSRRS, 5'd1), '0);
        issue(csr_word(CSR_MTVEC, 5'd0, F3_CSRRS, 5'd2), '0);
        issue(csr_word(CSR_MSCRATCH, 5'd0, F3_CSRRS, 5'd3), '0);
        issue(csr_word(CSR_MEPC, 5'd0, F3_CSRRSI, 5'd4), '0);
        issue(csr_word(CSR_MCAUSE, 5'd0, F3_CSRRCI, 5'd5), '0);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] word;
        logic [4:0]  src;
        seed = 6;
        rst = 1'b0;
        inst_valid = 1'b0;
        inst = '0;
        rs1_data = '0;
        exp0_we = 1'b0;
        exp0_ill = 1'b0;
        exp0_addr = '0;
        exp0_data = '0;
        m_mscratch = '0;
        m_mepc = '0;
        m_mcause = '0;
        m_mtvec = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b1;

        read_all(); // reset values
        idle(2);
        issue(csr_word(CSR_MSCRATCH, 5'd7, F3_CSRRW, 5'd2), 32'hdead_beef);
        issue(csr_word(CSR_MCAUSE, 5'h15, F3_CSRRWI, 5'd3), 32'hffff_ffff);
        issue(csr_word(CSR_MEPC, 5'd9, F3_CSRRW, 5'd0), 32'h8000_1235); // writes, no rd_we
        issue(csr_word(CSR_MTVEC, 5'd4, F3_CSRRW, 5'd5), 32'h1234_5677);
        read_all();
        for (int i = 0; i < 4; i++) begin
            r = $random(seed);
            issue(csr_word(RW_CSR[i], 5'd11, F3_CSRRS, 5'd6), $random(seed));
            issue(csr_word(RW_CSR[i], 5'd12, F3_CSRRC, 5'd7), $random(seed));
            issue(csr_word(RW_CSR[i], r[4:0] | 5'd1, F3_CSRRSI, 5'd8), '0);
            issue(csr_word(RW_CSR[i], r[9:5] | 5'd1, F3_CSRRCI, 5'd9), '0);
            issue(csr_word(RW_CSR[i], 5'd0, F3_CSRRS, 5'd10), $random(seed)); // only reads
            issue(csr_word(RW_CSR[i], 5'd0, F3_CSRRCI, 5'd11), '0);
        end
        read_all();
        issue(csr_word(12'h7c0, 5'd3, F3_CSRRW, 5'd12), 32'h5555_aaaa); // no such CSR
        issue(csr_word(12'h7c0, 5'd0, F3_CSRRS, 5'd12), '0);
        issue(csr_word(CSR_MISA, 5'd3, F3_CSRRW, 5'd13), 32'hffff_ffff);
        issue(csr_word(CSR_MISA, 5'd2, F3_CSRRSI, 5'd13), '0);
        issue(csr_word(CSR_MSCRATCH, 5'd3, F3_CSRRW, 5'd14) ^ 32'h40, 32'h1); // opcode 0x33
        issue(csr_word(CSR_MSCRATCH, 5'd3, 3'b000, 5'd14), 32'hffff_ffff);
        issue(csr_word(CSR_MEPC, 5'd3, 3'b100, 5'd14), 32'hffff_ffff);
        issue(csr_word(CSR_MISA, 5'd0, F3_CSRRS, 5'd15), 32'h1); // plain read of misa is fine
        issue(csr_word(CSR_MISA, 5'd0, F3_CSRRCI, 5'd15), '0);
        read_all();
        issue(csr_word(CSR_MSCRATCH, 5'd1, F3_CSRRW, 5'd16), 32'h0f0f_0f0f);
        issue(csr_word(CSR_MSCRATCH, 5'd2, F3_CSRRS, 5'd17), 32'h0000_fff0);
        issue(csr_word(CSR_MSCRATCH, 5'h1f, F3_CSRRCI, 5'd18), '0);
        issue(csr_word(CSR_MSCRATCH, 5'd3, F3_CSRRW, 5'd19), 32'h0);
        issue(csr_word(CSR_MSCRATCH, 5'd0, F3_CSRRS, 5'd20), '0);
        for (int i = 0; i < N_RANDOM; i++) begin
            r = $random(seed);
            src = (r[12:11] == 2'b00) ? 5'd0 : r[10:6]; // a quarter with a zero source field
            word = csr_word(ANY_CSR[r[2:0]], src, r[5:3], r[17:13]);
            if (r[22:18] == 5'd0) word = word ^ 32'h0000_0040; // rare foreign opcode
            issue(word, $random(seed));
        end
        idle(4);

        $display("checked %0d cycles, errors: rd_we %0d, illegal %0d, rd_addr %0d, rd_wdata %0d",
                 checked, err_we, err_ill, err_addr, err_data);
        if (err_we + err_ill + err_addr + err_data == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #((RESET_CYCLES + N_DIRECTED + N_RANDOM + MARGIN) * CLK_PERIOD);
        $display("timeout: stimulus did not complete in the expected time");
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/csr_pkg.sv
hw/csr_decode.sv
hw/csr_execute.sv
hw/csr_file.sv
hw/csr_result.sv
hw/csr_unit_top.sv
tb/csr_unit_tb.sv
